// File: source/ctrlPkg.sv
package ctrlPkg;

    localparam int insW = 32;
    localparam int regW = 5;

    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opRegImm  = 6'h01;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opBlez    = 6'h06;
    localparam logic [5:0] opBgtz    = 6'h07;
    localparam logic [5:0] opAddi    = 6'h08;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opSlti    = 6'h0a;
    localparam logic [5:0] opSltiu   = 6'h0b;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opXori    = 6'h0e;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLb      = 6'h20;
    localparam logic [5:0] opLh      = 6'h21;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opLbu     = 6'h24;
    localparam logic [5:0] opLhu     = 6'h25;
    localparam logic [5:0] opSb      = 6'h28;
    localparam logic [5:0] opSh      = 6'h29;
    localparam logic [5:0] opSw      = 6'h2b;

    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnSrl  = 6'h02;
    localparam logic [5:0] fnSra  = 6'h03;
    localparam logic [5:0] fnSllv = 6'h04;
    localparam logic [5:0] fnSrlv = 6'h06;
    localparam logic [5:0] fnSrav = 6'h07;
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnJalr = 6'h09;
    localparam logic [5:0] fnAdd  = 6'h20;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSub  = 6'h22;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnNor  = 6'h27;
    localparam logic [5:0] fnSlt  = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;

    typedef enum logic [3:0] {
        aluNop, aluAdd, aluSub, aluSll, aluSrl, aluSra, aluAnd,
        aluOr, aluXor, aluNor, aluSlt, aluSltu, aluLui
    } aluOpT;

    typedef enum logic [2:0] {
        pcSeq     = 3'd0,
        pcBranch  = 3'd1,
        pcJumpReg = 3'd2,
        pcJump    = 3'd3,
        pcHoldOne = 3'd4,
        pcHoldTwo = 3'd5
    } pcSrcT;

    typedef enum logic [1:0] {
        fwdNone   = 2'd0,
        fwdMem    = 2'd1,
        fwdWbLoad = 2'd2,
        fwdWbAlu  = 2'd3
    } fwdT;

    typedef enum logic [1:0] {ifIdFlush = 2'd0, ifIdRun = 2'd1, ifIdHold = 2'd2} ifIdT;

    typedef enum logic {idExBubble = 1'b0, idExRun = 1'b1} idExT;

    function automatic logic [5:0] opOf(input logic [insW-1:0] ins);
        return ins[31:26];
    endfunction

    function automatic logic [regW-1:0] rsOf(input logic [insW-1:0] ins);
        return ins[25:21];
    endfunction

    function automatic logic [regW-1:0] rtOf(input logic [insW-1:0] ins);
        return ins[20:16];
    endfunction

    function automatic logic [regW-1:0] rdOf(input logic [insW-1:0] ins);
        return ins[15:11];
    endfunction

    function automatic logic [5:0] fnOf(input logic [insW-1:0] ins);
        return ins[5:0];
    endfunction

    function automatic logic isLoad(input logic [insW-1:0] ins);
        return opOf(ins) inside {opLb, opLh, opLw, opLbu, opLhu};
    endfunction

    function automatic logic isStore(input logic [insW-1:0] ins);
        return opOf(ins) inside {opSb, opSh, opSw};
    endfunction

    // addi through lui
    function automatic logic isImmAlu(input logic [insW-1:0] ins);
        return opOf(ins) inside {opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui};
    endfunction

    function automatic logic [regW-1:0] destReg(input logic [insW-1:0] ins);
        if (opOf(ins) == opSpecial && fnOf(ins) != fnJr)
            return rdOf(ins);
        else if (isImmAlu(ins) || isLoad(ins))
            return rtOf(ins);
        return '0;
    endfunction

endpackage

// File: source/stageDecode.sv
`timescale 1ns/10ps

module stageDecode (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [ctrlPkg::insW-1:0] exIns,
    input  logic [ctrlPkg::insW-1:0] memIns,
    input  logic [ctrlPkg::insW-1:0] wbIns,
    output ctrlPkg::aluOpT           aluOp,
    output logic [1:0]               aluASrc,
    output logic [1:0]               aluBSrc,
    output logic                     dmWr,
    output logic                     rfWr,
    output logic [1:0]               wbAddrSrc,
    output logic [1:0]               wbDataSrc
);
    import ctrlPkg::*;

    aluOpT      aluOpNext;
    logic [1:0] aSrcNext;
    logic [1:0] bSrcNext;
    logic       rfWrNext;
    logic [1:0] addrSrcNext;
    logic [1:0] dataSrcNext;

    // execute stage alu control
    always_comb
    begin
        aluOpNext = aluNop;
        aSrcNext  = 2'd0;
        bSrcNext  = 2'd0;
        if (opOf(exIns) == opSpecial)
        begin
            // shift amount feeds operand a
            if (fnOf(exIns) inside {fnSll, fnSrl, fnSra})
                aSrcNext = 2'd1;
            case (fnOf(exIns))
                fnAdd, fnAddu, fnJr, fnJalr: aluOpNext = aluAdd;
                fnSub, fnSubu:               aluOpNext = aluSub;
                fnSll, fnSllv:               aluOpNext = aluSll;
                fnSrl, fnSrlv:               aluOpNext = aluSrl;
                fnSra, fnSrav:               aluOpNext = aluSra;
                fnAnd:                       aluOpNext = aluAnd;
                fnOr:                        aluOpNext = aluOr;
                fnXor:                       aluOpNext = aluXor;
                fnNor:                       aluOpNext = aluNor;
                fnSlt:                       aluOpNext = aluSlt;
                fnSltu:                      aluOpNext = aluSltu;
                default:                     aluOpNext = aluNop;
            endcase
        end
        else if (isImmAlu(exIns) || isLoad(exIns) || isStore(exIns))
        begin
            // zero-extended for logical ops and sltiu
            if (opOf(exIns) inside {opAndi, opOri, opXori, opSltiu})
                bSrcNext = 2'd2;
            else
                bSrcNext = 2'd1;
            case (opOf(exIns))
                opAndi:  aluOpNext = aluAnd;
                opOri:   aluOpNext = aluOr;
                opXori:  aluOpNext = aluXor;
                opLui:   aluOpNext = aluLui;
                opSlti:  aluOpNext = aluSlt;
                opSltiu: aluOpNext = aluSltu;
                default: aluOpNext = aluAdd;
            endcase
        end
    end

    // writeback enable and selects
    always_comb
    begin
        rfWrNext    = 1'b0;
        addrSrcNext = 2'd0;
        dataSrcNext = 2'd1;
        if (opOf(wbIns) == opSpecial)
        begin
            rfWrNext = (fnOf(wbIns) != fnJr);
            if (fnOf(wbIns) == fnJalr)
                dataSrcNext = 2'd2;
        end
        else if (isImmAlu(wbIns))
        begin
            rfWrNext    = 1'b1;
            addrSrcNext = 2'd1;
        end
        else if (isLoad(wbIns))
        begin
            rfWrNext    = 1'b1;
            addrSrcNext = 2'd1;
            dataSrcNext = 2'd0;
        end
        else if (opOf(wbIns) == opJal)
        begin
            // link into r31
            rfWrNext    = 1'b1;
            addrSrcNext = 2'd2;
            dataSrcNext = 2'd2;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            aluOp     <= aluNop;
            aluASrc   <= 2'd0;
            aluBSrc   <= 2'd0;
            dmWr      <= 1'b0;
            rfWr      <= 1'b0;
            wbAddrSrc <= 2'd0;
            wbDataSrc <= 2'd0;
        end
        else
        begin
            aluOp     <= aluOpNext;
            aluASrc   <= aSrcNext;
            aluBSrc   <= bSrcNext;
            dmWr      <= isStore(memIns);
            rfWr      <= rfWrNext;
            wbAddrSrc <= addrSrcNext;
            wbDataSrc <= dataSrcNext;
        end
    end

endmodule

// File: source/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [ctrlPkg::insW-1:0] idIns,
    input  logic [ctrlPkg::insW-1:0] exIns,
    input  logic [ctrlPkg::insW-1:0] memIns,
    input  logic [ctrlPkg::insW-1:0] wbIns,
    output ctrlPkg::fwdT             fwdA,
    output ctrlPkg::fwdT             fwdB,
    output logic                     stallOne,
    output logic                     stallTwo
);
    import ctrlPkg::*;

    logic [regW-1:0] exDest;
    logic [regW-1:0] memDest;
    logic [regW-1:0] wbDest;
    logic [regW-1:0] idRs;
    logic [regW-1:0] idRt;
    logic            idJumpReg;
    logic            idBranch;
    logic            idAluReg;

    // memory stage wins over writeback
    function automatic fwdT pickFwd(
        input logic [regW-1:0] src,
        input logic [regW-1:0] memD,
        input logic [regW-1:0] wbD,
        input logic            wbLoad
    );
        if (memD != '0 && src == memD)
            return fwdMem;
        if (wbD != '0 && src == wbD)
            return wbLoad ? fwdWbLoad : fwdWbAlu;
        return fwdNone;
    endfunction

    assign exDest  = destReg(exIns);
    assign memDest = destReg(memIns);
    assign wbDest  = destReg(wbIns);
    assign idRs    = rsOf(idIns);
    assign idRt    = rtOf(idIns);

    assign idJumpReg = opOf(idIns) == opSpecial && fnOf(idIns) inside {fnJr, fnJalr};
    assign idBranch  = opOf(idIns) inside {opRegImm, opBeq, opBne, opBlez, opBgtz};
    assign idAluReg  = opOf(idIns) == opSpecial && !idJumpReg;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            fwdA <= fwdNone;
            fwdB <= fwdNone;
        end
        else
        begin
            fwdA <= pickFwd(rsOf(exIns), memDest, wbDest, isLoad(wbIns));
            fwdB <= pickFwd(rtOf(exIns), memDest, wbDest, isLoad(wbIns));
        end
    end

    always_comb
    begin
        stallOne = 1'b0;
        stallTwo = 1'b0;
        // decode needs its operands now for jumps and branches
        if (idJumpReg)
        begin
            if (exDest != '0 && idRs == exDest)
                stallTwo = 1'b1;
            else if (memDest != '0 && idRs == memDest)
                stallOne = 1'b1;
        end
        if (idBranch)
        begin
            if (exDest != '0 && (idRs == exDest || idRt == exDest))
                stallTwo = 1'b1;
            else if (memDest != '0 && (idRs == memDest || idRt == memDest))
                stallOne = 1'b1;
        end
        // load use, exDest is the load's rt here
        if (isLoad(exIns) && exDest != '0)
        begin
            if (isStore(idIns))
            begin
                if (idRs == exDest)
                    stallOne = 1'b1;
                if (idRt == exDest)
                    stallTwo = 1'b1;
            end
            else if (isImmAlu(idIns) && idRs == exDest)
                stallOne = 1'b1;
            else if (idAluReg && (idRs == exDest || idRt == exDest))
                stallOne = 1'b1;
        end
    end

endmodule

// File: source/branchUnit.sv
`timescale 1ns/10ps

module branchUnit (
    input  logic [ctrlPkg::insW-1:0] idIns,
    input  logic [ctrlPkg::insW-1:0] rd1,
    input  logic [ctrlPkg::insW-1:0] rd2,
    output ctrlPkg::pcSrcT           redirect,
    output logic                     takeFlush
);
    import ctrlPkg::*;

    logic signed [insW-1:0] sRd1;
    logic                   taken;

    assign sRd1 = rd1;

    // conditional branch outcome
    always_comb
    begin
        case (opOf(idIns))
            opBeq:    taken = (rd1 == rd2);
            opBne:    taken = (rd1 != rd2);
            opBlez:   taken = (sRd1 <= 0);
            opBgtz:   taken = (sRd1 > 0);
            // bgez when rt is 1, bltz otherwise
            opRegImm: taken = (rtOf(idIns) == regW'(1)) ? (sRd1 >= 0) : (sRd1 < 0);
            default:  taken = 1'b0;
        endcase
    end

    always_comb
    begin
        redirect = pcSeq;
        case (opOf(idIns))
            opSpecial:
            begin
                if (fnOf(idIns) == fnJr || fnOf(idIns) == fnJalr)
                    redirect = pcJumpReg;
            end
            opJ, opJal:
                redirect = pcJump;
            default:
            begin
                if (taken)
                    redirect = pcBranch;
            end
        endcase
    end

    assign takeFlush = (redirect != pcSeq);

endmodule

// File: source/pcSteer.sv
`timescale 1ns/10ps

module pcSteer (
    input  logic             clk,
    input  logic             rstN,
    input  logic             stallOne,
    input  logic             stallTwo,
    input  logic             takeFlush,
    input  ctrlPkg::pcSrcT   redirect,
    output ctrlPkg::pcSrcT   pcSrc,
    output ctrlPkg::ifIdT    ifIdCtl,
    output ctrlPkg::idExT    idExCtl
);
    import ctrlPkg::*;

    pcSrcT pcNext;
    ifIdT  ifIdNext;

    // stalls take priority over the redirect
    always_comb
    begin
        if (stallTwo)
            pcNext = pcHoldTwo;
        else if (stallOne)
            pcNext = pcHoldOne;
        else
            pcNext = redirect;
    end

    // later rules override earlier ones
    always_comb
    begin
        ifIdNext = ifIdRun;
        if (stallTwo)
            ifIdNext = ifIdFlush;
        if (stallOne)
            ifIdNext = ifIdHold;
        if (takeFlush)
            ifIdNext = ifIdFlush;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            pcSrc   <= pcSeq;
            ifIdCtl <= ifIdFlush;
            idExCtl <= idExBubble;
        end
        else
        begin
            pcSrc   <= pcNext;
            ifIdCtl <= ifIdNext;
            idExCtl <= (stallOne || stallTwo) ? idExBubble : idExRun;
        end
    end

endmodule

// File: source/pipeCtrl.sv
`timescale 1ns/10ps

module pipeCtrl (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [ctrlPkg::insW-1:0] idIns,
    input  logic [ctrlPkg::insW-1:0] exIns,
    input  logic [ctrlPkg::insW-1:0] memIns,
    input  logic [ctrlPkg::insW-1:0] wbIns,
    input  logic [ctrlPkg::insW-1:0] rd1,
    input  logic [ctrlPkg::insW-1:0] rd2,
    output ctrlPkg::aluOpT           aluOp,
    output logic [1:0]               aluASrc,
    output logic [1:0]               aluBSrc,
    output logic                     dmWr,
    output logic                     rfWr,
    output logic [1:0]               wbAddrSrc,
    output logic [1:0]               wbDataSrc,
    output ctrlPkg::fwdT             fwdA,
    output ctrlPkg::fwdT             fwdB,
    output ctrlPkg::pcSrcT           pcSrc,
    output ctrlPkg::ifIdT            ifIdCtl,
    output ctrlPkg::idExT            idExCtl
);
    import ctrlPkg::*;

    logic  stallOne;
    logic  stallTwo;
    logic  takeFlush;
    pcSrcT redirect;

    stageDecode uDecode (
        .clk      (clk),
        .rstN     (rstN),
        .exIns    (exIns),
        .memIns   (memIns),
        .wbIns    (wbIns),
        .aluOp    (aluOp),
        .aluASrc  (aluASrc),
        .aluBSrc  (aluBSrc),
        .dmWr     (dmWr),
        .rfWr     (rfWr),
        .wbAddrSrc(wbAddrSrc),
        .wbDataSrc(wbDataSrc)
    );

    hazardUnit uHazard (
        .clk     (clk),
        .rstN    (rstN),
        .idIns   (idIns),
        .exIns   (exIns),
        .memIns  (memIns),
        .wbIns   (wbIns),
        .fwdA    (fwdA),
        .fwdB    (fwdB),
        .stallOne(stallOne),
        .stallTwo(stallTwo)
    );

    branchUnit uBranch (
        .idIns    (idIns),
        .rd1      (rd1),
        .rd2      (rd2),
        .redirect (redirect),
        .takeFlush(takeFlush)
    );

    pcSteer uSteer (
        .clk      (clk),
        .rstN     (rstN),
        .stallOne (stallOne),
        .stallTwo (stallTwo),
        .takeFlush(takeFlush),
        .redirect (redirect),
        .pcSrc    (pcSrc),
        .ifIdCtl  (ifIdCtl),
        .idExCtl  (idExCtl)
    );

endmodule

// File: verif/ctrlModel.svh
`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

function automatic logic loadOp(input logic [31:0] ins);
    return ins[31:26] inside {opLb, opLh, opLw, opLbu, opLhu};
endfunction

function automatic logic storeOp(input logic [31:0] ins);
    return ins[31:26] inside {opSb, opSh, opSw};
endfunction

// opcodes 0x08 to 0x0f
function automatic logic immOp(input logic [31:0] ins);
    return ins[31:29] == 3'b001;
endfunction

function automatic logic jumpRegOp(input logic [31:0] ins);
    return ins[31:26] == opSpecial && (ins[5:0] == fnJr || ins[5:0] == fnJalr);
endfunction

function automatic logic branchOp(input logic [31:0] ins);
    return ins[31:26] inside {opRegImm, opBeq, opBne, opBlez, opBgtz};
endfunction

function automatic logic [4:0] writtenReg(input logic [31:0] ins);
    if (ins[31:26] == opSpecial)
        return (ins[5:0] == fnJr) ? 5'd0 : ins[15:11];
    if (immOp(ins) || loadOp(ins))
        return ins[20:16];
    return 5'd0;
endfunction

// {aluOp, a select, b select}
function automatic logic [7:0] aluExpect(input logic [31:0] ex);
    logic [5:0] fn;
    logic [2:0] low;
    logic [3:0] op;
    logic [1:0] aSel;
    logic [1:0] bSel;
    fn = ex[5:0];
    low = ex[28:26];
    op = aluNop;
    aSel = 2'd0;
    bSel = 2'd0;
    if (ex[31:26] == opSpecial)
    begin
        // shift group 0x00 to 0x07, bit 2 marks the variable form
        if (fn[5:3] == 3'b000 && fn[1:0] != 2'b01)
        begin
            op = (fn[1:0] == 2'b00) ? aluSll : (fn[0] ? aluSra : aluSrl);
            aSel = fn[2] ? 2'd0 : 2'd1;
        end
        else if (fn[5:1] == 5'b00100)
            op = aluAdd;
        else if (fn[5:3] == 3'b100)
        begin
            // add, sub, and, or, xor, nor
            case (fn[2:0])
                3'd0, 3'd1: op = aluAdd;
                3'd2, 3'd3: op = aluSub;
                3'd4:       op = aluAnd;
                3'd5:       op = aluOr;
                3'd6:       op = aluXor;
                default:    op = aluNor;
            endcase
        end
        else if (fn[5:1] == 5'b10101)
            op = fn[0] ? aluSltu : aluSlt;
    end
    else if (immOp(ex))
    begin
        // low opcode bits run add, add, slt, sltu, and, or, xor, lui
        case (low)
            3'd0, 3'd1: op = aluAdd;
            3'd2:       op = aluSlt;
            3'd3:       op = aluSltu;
            3'd4:       op = aluAnd;
            3'd5:       op = aluOr;
            3'd6:       op = aluXor;
            default:    op = aluLui;
        endcase
        // andi, ori, xori and sltiu zero extend
        bSel = (low == 3'd3 || (low[2] && low != 3'd7)) ? 2'd2 : 2'd1;
    end
    else if (loadOp(ex) || storeOp(ex))
    begin
        op = aluAdd;
        bSel = 2'd1;
    end
    return {op, aSel, bSel};
endfunction

// {rfWr, address select, data select}
function automatic logic [4:0] wbExpect(input logic [31:0] wb);
    if (wb[31:26] == opSpecial)
        return {wb[5:0] != fnJr, 2'd0, (wb[5:0] == fnJalr) ? 2'd2 : 2'd1};
    if (immOp(wb))
        return {1'b1, 2'd1, 2'd1};
    if (loadOp(wb))
        return {1'b1, 2'd1, 2'd0};
    if (wb[31:26] == opJal)
        return {1'b1, 2'd2, 2'd2};
    return {1'b0, 2'd0, 2'd1};
endfunction

function automatic logic [1:0] fwdExpect(
    input logic [4:0]  src,
    input logic [31:0] mem,
    input logic [31:0] wb
);
    if (src == 5'd0)
        return fwdNone;
    if (src == writtenReg(mem))
        return fwdMem;
    if (src == writtenReg(wb))
        return loadOp(wb) ? fwdWbLoad : fwdWbAlu;
    return fwdNone;
endfunction

// {stallTwo, stallOne}
function automatic logic [1:0] stallExpect(
    input logic [31:0] id,
    input logic [31:0] ex,
    input logic [31:0] mem
);
    logic [4:0] exD;
    logic [4:0] memD;
    logic [4:0] rs;
    logic [4:0] rt;
    logic       one;
    logic       two;
    exD = writtenReg(ex);
    memD = writtenReg(mem);
    rs = id[25:21];
    rt = id[20:16];
    one = 1'b0;
    two = 1'b0;
    // jr and jalr read rs only, branches read both
    if (jumpRegOp(id) || branchOp(id))
    begin
        if (exD != 5'd0 && (rs == exD || (branchOp(id) && rt == exD)))
            two = 1'b1;
        else if (memD != 5'd0 && (rs == memD || (branchOp(id) && rt == memD)))
            one = 1'b1;
    end
    else if (loadOp(ex) && exD != 5'd0)
    begin
        if (storeOp(id))
        begin
            one = (rs == exD);
            two = (rt == exD);
        end
        else if (immOp(id))
            one = (rs == exD);
        else if (id[31:26] == opSpecial)
            one = (rs == exD || rt == exD);
    end
    return {two, one};
endfunction

function automatic logic [2:0] redirectExpect(
    input logic [31:0] id,
    input logic [31:0] rd1,
    input logic [31:0] rd2
);
    logic take;
    case (id[31:26])
        opBeq:    take = (rd1 == rd2);
        opBne:    take = (rd1 != rd2);
        opBlez:   take = rd1[31] || rd1 == 32'd0;
        opBgtz:   take = !rd1[31] && rd1 != 32'd0;
        opRegImm: take = (id[20:16] == 5'd1) ? !rd1[31] : rd1[31];
        default:  take = 1'b0;
    endcase
    if (jumpRegOp(id))
        return pcJumpReg;
    if (id[31:26] == opJ || id[31:26] == opJal)
        return pcJump;
    return take ? pcBranch : pcSeq;
endfunction

// all outputs packed in port order, 24 bits
function automatic logic [23:0] expectAll(
    input logic [31:0] id,
    input logic [31:0] ex,
    input logic [31:0] mem,
    input logic [31:0] wb,
    input logic [31:0] rd1,
    input logic [31:0] rd2
);
    logic [1:0] stall;
    logic [2:0] redir;
    logic [2:0] pc;
    logic [1:0] ifId;
    logic       idEx;
    stall = stallExpect(id, ex, mem);
    redir = redirectExpect(id, rd1, rd2);
    pc = stall[1] ? pcHoldTwo : (stall[0] ? pcHoldOne : redir);
    if (redir != pcSeq)
        ifId = ifIdFlush;
    else if (stall[0])
        ifId = ifIdHold;
    else if (stall[1])
        ifId = ifIdFlush;
    else
        ifId = ifIdRun;
    idEx = (stall == 2'b00);
    return {aluExpect(ex), storeOp(mem), wbExpect(wb), fwdExpect(ex[25:21], mem, wb),
            fwdExpect(ex[20:16], mem, wb), pc, ifId, idEx};
endfunction

`endif

// File: verif/pipeCtrlTb.sv
`timescale 1ns/10ps

module pipeCtrlTb;
    import ctrlPkg::*;

    `include "ctrlModel.svh"

    localparam int testCycles = 400;
    localparam int numTests   = 5;
    localparam int cycleLimit = numTests * testCycles + 1000;

    localparam int kindAny     = 0;
    localparam int kindWriter  = 1;
    localparam int kindControl = 2;
    localparam int kindNoDest  = 3;

    logic            clk;
    logic            rstN;
    logic [insW-1:0] idIns;
    logic [insW-1:0] exIns;
    logic [insW-1:0] memIns;
    logic [insW-1:0] wbIns;
    logic [insW-1:0] rd1;
    logic [insW-1:0] rd2;
    aluOpT           aluOp;
    logic [1:0]      aluASrc;
    logic [1:0]      aluBSrc;
    logic            dmWr;
    logic            rfWr;
    logic [1:0]      wbAddrSrc;
    logic [1:0]      wbDataSrc;
    fwdT             fwdA;
    fwdT             fwdB;
    pcSrcT           pcSrc;
    ifIdT            ifIdCtl;
    idExT            idExCtl;

    int              seed;
    int              cycleCount;
    int              checkCount;
    int              errCount;
    logic [23:0]     expQ [$];

    // special listed three times so jr and register ALU ops come up often
    logic [5:0] opTable [26] = '{opSpecial, opSpecial, opSpecial, opRegImm, opJ, opJal,
        opBeq, opBne, opBlez, opBgtz, opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri,
        opXori, opLui, opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw};
    logic [5:0] fnTable [18] = '{fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav, fnJr, fnJalr,
        fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu};
    logic [31:0] dataSet [7] = '{32'h8000_0000, 32'hffff_fffb, 32'hffff_ffff, 32'h0,
        32'h1, 32'h7, 32'h7fff_ffff};

    pipeCtrl DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
        cycleCount <= cycleCount + 1;

    initial
    begin
        wait (cycleCount >= cycleLimit);
        $display("timeout: the run hung and was stopped after %0d cycles", cycleCount);
        $display("Checks failed");
        $finish;
    end

    function automatic int pickBelow(input int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    function automatic logic [31:0] makeIns();
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  rs, rt, rd, sh;
        logic [15:0] imm;
        op = opTable[5'(pickBelow(26))];
        fn = fnTable[5'(pickBelow(18))];
        // registers 0 to 3 keep hazards frequent
        rs = 5'(pickBelow(4));
        rt = 5'(pickBelow(4));
        rd = 5'(pickBelow(4));
        sh = 5'(pickBelow(32));
        imm = 16'(pickBelow(65536));
        if (op == opSpecial)
            return {op, rs, rt, rd, sh, fn};
        return {op, rs, rt, imm};
    endfunction

    function automatic logic fitsKind(input logic [31:0] ins, input int kind);
        case (kind)
            kindWriter:  return (ins[31:26] == opSpecial && ins[5:0] != fnJr)
                                || immOp(ins) || loadOp(ins);
            kindControl: return jumpRegOp(ins) || branchOp(ins)
                                || ins[31:26] == opJ || ins[31:26] == opJal;
            kindNoDest:  return writtenReg(ins) == 5'd0;
            default:     return 1'b1;
        endcase
    endfunction

    function automatic logic [31:0] randIns(input int kind);
        logic [31:0] ins;
        int          tries;
        ins = makeIns();
        tries = 0;
        while (!fitsKind(ins, kind) && tries < 64)
        begin
            ins = makeIns();
            tries++;
        end
        return ins;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected)
        begin
            errCount++;
            $display("[FAIL] %s expected %0h actual %0h", what, expected, actual);
        end
    endtask

    task automatic compareOutputs(input string test, input logic [23:0] expected);
        checkValue({test, " aluOp"}, 32'(expected[23:20]), 32'(aluOp));
        checkValue({test, " aluASrc"}, 32'(expected[19:18]), 32'(aluASrc));
        checkValue({test, " aluBSrc"}, 32'(expected[17:16]), 32'(aluBSrc));
        checkValue({test, " dmWr"}, 32'(expected[15]), 32'(dmWr));
        checkValue({test, " rfWr"}, 32'(expected[14]), 32'(rfWr));
        checkValue({test, " wbAddrSrc"}, 32'(expected[13:12]), 32'(wbAddrSrc));
        checkValue({test, " wbDataSrc"}, 32'(expected[11:10]), 32'(wbDataSrc));
        checkValue({test, " fwdA"}, 32'(expected[9:8]), 32'(fwdA));
        checkValue({test, " fwdB"}, 32'(expected[7:6]), 32'(fwdB));
        checkValue({test, " pcSrc"}, 32'(expected[5:3]), 32'(pcSrc));
        checkValue({test, " ifIdCtl"}, 32'(expected[2:1]), 32'(ifIdCtl));
        checkValue({test, " idExCtl"}, 32'(expected[0]), 32'(idExCtl));
    endtask

    // called right after a rising edge
    task automatic driveRandom(input int idK, input int exK, input int memK, input int wbK,
                               output logic [23:0] expected);
        logic [31:0] i0, i1, i2, i3;
        logic [31:0] a;
        logic [31:0] b;
        i0 = randIns(idK);
        i1 = randIns(exK);
        i2 = randIns(memK);
        i3 = randIns(wbK);
        a = dataSet[3'(pickBelow(7))];
        b = (pickBelow(4) == 0) ? a : dataSet[3'(pickBelow(7))];
        idIns <= i0;
        exIns <= i1;
        memIns <= i2;
        wbIns <= i3;
        rd1 <= a;
        rd2 <= b;
        expected = expectAll(i0, i1, i2, i3, a, b);
    endtask

    task automatic stepCycle(input string test, input int idK, input int exK,
                             input int memK, input int wbK);
        logic [23:0] expected;
        @(posedge clk);
        driveRandom(idK, exK, memK, wbK, expected);
        expQ.push_back(expected);
        @(negedge clk);
        if (expQ.size() > 1)
            compareOutputs(test, expQ.pop_front());
    endtask

    task automatic drainCycle(input string test);
        @(posedge clk);
        @(negedge clk);
        while (expQ.size() > 0)
            compareOutputs(test, expQ.pop_front());
    endtask

    task automatic resetTest();
        logic [23:0] expected;
        int          errBefore;
        int          chkBefore;
        errBefore = errCount;
        chkBefore = checkCount;
        @(posedge clk);
        driveRandom(kindAny, kindAny, kindAny, kindAny, expected);
        @(negedge clk);
        compareOutputs("reset", 24'd0);
        @(posedge clk);
        driveRandom(kindAny, kindAny, kindAny, kindAny, expected);
        rstN <= 1'b1;
        expQ.push_back(expected);
        // released, but nothing sampled yet
        @(negedge clk);
        compareOutputs("reset release", 24'd0);
        drainCycle("reset");
        $display("reset: %0d checks, %0d failures", checkCount - chkBefore,
                 errCount - errBefore);
    endtask

    task automatic runTest(input string test, input int idK, input int exK,
                           input int memK, input int wbK);
        int errBefore;
        int chkBefore;
        errBefore = errCount;
        chkBefore = checkCount;
        repeat (testCycles)
            stepCycle(test, idK, exK, memK, wbK);
        drainCycle(test);
        $display("%s: %0d checks, %0d failures", test, checkCount - chkBefore,
                 errCount - errBefore);
    endtask

    initial
    begin
        seed = 32'h9e36_d0e8;
        cycleCount = 0;
        checkCount = 0;
        errCount = 0;
        rstN = 1'b0;
        idIns = '0;
        exIns = '0;
        memIns = '0;
        wbIns = '0;
        rd1 = '0;
        rd2 = '0;
        resetTest();
        runTest("decode", kindAny, kindAny, kindAny, kindAny);
        runTest("forwarding", kindAny, kindWriter, kindWriter, kindWriter);
        // execute and memory write nothing here
        runTest("redirect", kindControl, kindNoDest, kindNoDest, kindAny);
        runTest("stall", kindAny, kindWriter, kindWriter, kindAny);
        $display("total: %0d checks, %0d failures", checkCount, errCount);
        if (errCount == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: src.f
+incdir+verif
source/ctrlPkg.sv
source/stageDecode.sv
source/hazardUnit.sv
source/branchUnit.sv
source/pcSteer.sv
source/pipeCtrl.sv
verif/pipeCtrlTb.sv

// File: Makefile
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module pipeCtrlTb

sim:
	verilator --binary --timing -j 0 -f src.f --top-module pipeCtrlTb -Mdir obj_dir
	./obj_dir/VpipeCtrlTb | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "All checks passed" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
